//--- dma_pkg.sv
// dma engine package with widths, register map, control fields and port structs.
package dma_pkg;

    localparam int ADDR_W = 24;                  // byte address and count width.
    localparam int MAX_CHAN = 4;
    localparam int CHAN_ID_W = $clog2(MAX_CHAN); // channel number and response tag.
    localparam int NUM_REQ = 16;                 // request lines.
    localparam int REG_OFF_W = 6;                // 16 bytes per channel.

    // word offsets inside one channel's register window.
    localparam logic [3:0] OFF_SRC = 4'h0;
    localparam logic [3:0] OFF_DST = 4'h4;
    localparam logic [3:0] OFF_CTRL = 4'h8;
    localparam logic [3:0] OFF_CNT = 4'hC;

    typedef enum logic [1:0] {
        SIZE_8 = 2'd0,
        SIZE_16 = 2'd1,
        SIZE_32 = 2'd2
    } xfer_size_e;

    typedef struct packed {
        logic       null_term;  // a zero item ends the transfer.
        xfer_size_e size;
        logic       dst_inc;
        logic       src_inc;
        logic [3:0] dst_req;    // request line select.
        logic [3:0] src_req;
    } chan_ctrl_t;

    typedef struct packed {
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        chan_ctrl_t        ctrl;
        logic [ADDR_W-1:0] cnt;
    } chan_regs_t;

    typedef struct packed {
        logic                 wr;
        logic [REG_OFF_W-1:0] off;
        logic [31:0]          wdata;
        logic                 sel;
    } reg_req_t;

    typedef struct packed {
        logic                 wr;
        logic [CHAN_ID_W-1:0] tag;   // issuing channel.
        logic [3:0]           mask;
        logic [ADDR_W-1:0]    addr;  // word aligned.
        logic [31:0]          wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 wr;
        logic [CHAN_ID_W-1:0] tag;
        logic [3:0]           mask;
        logic [31:0]          rdata;
    } mem_rsp_t;

endpackage

//--- dma_reg_file.sv
// dma channel register bank with software access, engine updates and done status.
`timescale 1ns/1ns

module dma_reg_file
    import dma_pkg::*;
#(
    parameter int NUM_CHAN = 4
)
(
    input  logic                clk,
    input  logic                rst,
    input  reg_req_t            reg_req,
    input  logic [NUM_CHAN-1:0] update,
    input  logic [NUM_CHAN-1:0] null_clear,
    input  logic [ADDR_W-1:0]   next_src,
    input  logic [ADDR_W-1:0]   next_dst,
    input  logic [ADDR_W-1:0]   next_cnt,
    input  logic [NUM_CHAN-1:0] read_pending,
    input  logic [NUM_CHAN-1:0] write_pending,
    output logic [31:0]         reg_rdata,
    output chan_regs_t          regs [NUM_CHAN],
    output logic [NUM_CHAN-1:0] done
);

    localparam int CTRL_W = $bits(chan_ctrl_t);

    logic                 wr_en;
    logic [CHAN_ID_W-1:0] acc_chan;
    logic [3:0]           acc_word;

    assign wr_en = reg_req.sel && reg_req.wr;
    assign acc_chan = reg_req.off[REG_OFF_W-1:4];
    assign acc_word = reg_req.off[3:0];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_CHAN; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < NUM_CHAN; i++)
            begin
                if (wr_en && (acc_chan == CHAN_ID_W'(i)) && (acc_word == OFF_SRC))
                    regs[i].src <= reg_req.wdata[ADDR_W-1:0];
                else if (update[i] && regs[i].ctrl.src_inc)
                    regs[i].src <= next_src;

                if (wr_en && (acc_chan == CHAN_ID_W'(i)) && (acc_word == OFF_DST))
                    regs[i].dst <= reg_req.wdata[ADDR_W-1:0];
                else if (update[i] && regs[i].ctrl.dst_inc)
                    regs[i].dst <= next_dst;

                if (wr_en && (acc_chan == CHAN_ID_W'(i)) && (acc_word == OFF_CTRL))
                    regs[i].ctrl <= chan_ctrl_t'(reg_req.wdata[CTRL_W-1:0]);

                // a nonzero count written here starts the channel.
                if (wr_en && (acc_chan == CHAN_ID_W'(i)) && (acc_word == OFF_CNT))
                    regs[i].cnt <= reg_req.wdata[ADDR_W-1:0];
                else if (null_clear[i])
                    regs[i].cnt <= '0;
                else if (update[i])
                    regs[i].cnt <= next_cnt;
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            done <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_CHAN; i++)
            begin
                done[i] <= (regs[i].cnt == '0) && !read_pending[i] && !write_pending[i];
            end
        end
    end

    always_comb
    begin
        reg_rdata = '0;
        if (int'(acc_chan) < NUM_CHAN)
        begin
            case (acc_word)
                OFF_SRC:  reg_rdata = 32'(regs[acc_chan].src);
                OFF_DST:  reg_rdata = 32'(regs[acc_chan].dst);
                OFF_CTRL: reg_rdata = {done[acc_chan], 18'd0, regs[acc_chan].ctrl};
                OFF_CNT:  reg_rdata = 32'(regs[acc_chan].cnt);
                default:  reg_rdata = '0;
            endcase
        end
    end

endmodule

//--- dma_step_calc.sv
// dma address, count and byte lane calculation for the selected channel.
`timescale 1ns/1ns

module dma_step_calc
    import dma_pkg::*;
(
    input  chan_regs_t        regs_sel,
    output logic [ADDR_W-1:0] next_src,
    output logic [ADDR_W-1:0] next_dst,
    output logic [ADDR_W-1:0] next_cnt,
    output logic [3:0]        src_mask,
    output logic [3:0]        dst_mask
);

    always_comb
    begin
        case (regs_sel.ctrl.size)
            SIZE_8:
            begin
                next_src = regs_sel.src + ADDR_W'(1);
                next_dst = regs_sel.dst + ADDR_W'(1);
                next_cnt = regs_sel.cnt - ADDR_W'(1);
                src_mask = 4'b0001 << regs_sel.src[1:0];
                dst_mask = 4'b0001 << regs_sel.dst[1:0];
            end
            SIZE_16:
            begin
                next_src = (regs_sel.src + ADDR_W'(2)) & ~ADDR_W'(1);
                next_dst = (regs_sel.dst + ADDR_W'(2)) & ~ADDR_W'(1);
                next_cnt = (regs_sel.cnt - ADDR_W'(2)) & ~ADDR_W'(1);
                src_mask = regs_sel.src[1] ? 4'b1100 : 4'b0011;
                dst_mask = regs_sel.dst[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                // size code 3 also runs as a word transfer.
                next_src = (regs_sel.src + ADDR_W'(4)) & ~ADDR_W'(3);
                next_dst = (regs_sel.dst + ADDR_W'(4)) & ~ADDR_W'(3);
                next_cnt = (regs_sel.cnt - ADDR_W'(4)) & ~ADDR_W'(3);
                src_mask = 4'b1111;
                dst_mask = 4'b1111;
            end
        endcase
    end

endmodule

//--- dma_scheduler.sv
// dma channel arbitration, per-channel transfer FSM and memory request issue.
`timescale 1ns/1ns

module dma_scheduler
    import dma_pkg::*;
#(
    parameter int NUM_CHAN = 4
)
(
    input  logic                clk,
    input  logic                rst,
    input  chan_regs_t          regs [NUM_CHAN],
    input  logic [NUM_REQ-1:0]  req,
    input  logic [3:0]          src_mask,
    input  logic [3:0]          dst_mask,
    input  logic [NUM_CHAN-1:0] read_pending,
    input  logic [NUM_CHAN-1:0] write_pending,
    input  logic [31:0]         rdata_chan [NUM_CHAN],
    input  logic                mem_req_ready,
    output chan_regs_t          regs_sel,
    output mem_req_t            mem_req,
    output logic                mem_req_valid,
    output logic [NUM_CHAN-1:0] update,
    output logic [NUM_CHAN-1:0] null_clear
);

    localparam logic [1:0] ST_READ = 2'd0;
    localparam logic [1:0] ST_WRITE = 2'd1;
    localparam logic [1:0] ST_UPDATE = 2'd2;

    logic [NUM_REQ-1:0]   req_q;
    logic [CHAN_ID_W-1:0] chan_num;
    logic [CHAN_ID_W-1:0] chan_pick;
    logic [1:0]           state_q [NUM_CHAN];
    logic [1:0]           state_cur;
    logic [1:0]           state_next;
    logic [NUM_CHAN-1:0]  chan_sel;
    logic [31:0]          chan_rdata;
    logic                 chan_rpend;
    logic                 chan_wpend;
    logic                 src_req;
    logic                 dst_req;
    logic                 stall;
    logic                 stall_q;

    assign stall = mem_req_valid && !mem_req_ready;

    always_ff @(posedge clk)
        req_q <= req;

    // lowest channel with work left and no read in flight.
    always_comb
    begin
        chan_pick = CHAN_ID_W'(NUM_CHAN - 1);
        for (int i = NUM_CHAN - 1; i >= 0; i--)
        begin
            if ((regs[i].cnt != '0) && !read_pending[i])
                chan_pick = CHAN_ID_W'(i);
        end
    end

    always_comb
    begin
        regs_sel = regs[chan_num];
        state_cur = state_q[chan_num];
        chan_rdata = rdata_chan[chan_num];
        chan_rpend = read_pending[chan_num];
        chan_wpend = write_pending[chan_num];
        src_req = req_q[regs_sel.ctrl.src_req] || stall_q; // a waiting request stays up.
        dst_req = req_q[regs_sel.ctrl.dst_req] || stall_q;
        chan_sel = '0;
        chan_sel[chan_num] = 1'b1;
    end

    always_comb
    begin
        state_next = state_cur;
        mem_req = '0;
        mem_req_valid = 1'b0;
        update = '0;
        null_clear = '0;

        if (regs_sel.cnt == '0)
        begin
            state_next = ST_READ;
        end
        else
        begin
            case (state_cur)
                ST_READ:
                begin
                    if (src_req && !chan_rpend)
                    begin
                        mem_req_valid = 1'b1;
                        mem_req.tag = chan_num;
                        mem_req.mask = src_mask;
                        mem_req.addr = {regs_sel.src[ADDR_W-1:2], 2'b00};
                        if (mem_req_ready)
                            state_next = ST_WRITE;
                    end
                end
                ST_WRITE:
                begin
                    if (dst_req && !chan_rpend && !chan_wpend)
                    begin
                        mem_req_valid = 1'b1;
                        mem_req.wr = 1'b1;
                        mem_req.tag = chan_num;
                        mem_req.mask = dst_mask;
                        mem_req.addr = {regs_sel.dst[ADDR_W-1:2], 2'b00};
                        mem_req.wdata = chan_rdata;
                        if (mem_req_ready)
                            state_next = ST_UPDATE;
                    end
                end
                ST_UPDATE:
                begin
                    update = chan_sel;
                    if (regs_sel.ctrl.null_term && (chan_rdata == '0))
                        null_clear = chan_sel;
                    state_next = ST_READ;
                end
                default:
                    state_next = ST_READ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            chan_num <= '0;
            stall_q <= 1'b0;
            for (int i = 0; i < NUM_CHAN; i++)
            begin
                state_q[i] <= ST_READ;
            end
        end
        else
        begin
            if (!stall)
                chan_num <= chan_pick;  // held while the request waits.
            stall_q <= stall;
            for (int i = 0; i < NUM_CHAN; i++)
            begin
                if (chan_sel[i])
                    state_q[i] <= state_next;
            end
        end
    end

endmodule

//--- dma_resp_tracker.sv
// dma outstanding access tracking and per-channel capture of read data.
`timescale 1ns/1ns

module dma_resp_tracker
    import dma_pkg::*;
#(
    parameter int NUM_CHAN = 4
)
(
    input  logic                clk,
    input  logic                rst,
    input  mem_req_t            mem_req,
    input  logic                mem_req_valid,
    input  logic                mem_req_ready,
    input  mem_rsp_t            mem_rsp,
    input  logic                mem_rsp_valid,
    output logic [NUM_CHAN-1:0] read_pending,
    output logic [NUM_CHAN-1:0] write_pending,
    output logic [31:0]         rdata_chan [NUM_CHAN]
);

    logic                accept;
    logic [NUM_CHAN-1:0] set_rd;
    logic [NUM_CHAN-1:0] set_wr;
    logic [NUM_CHAN-1:0] clr_rd;
    logic [NUM_CHAN-1:0] clr_wr;
    logic [31:0]         rsp_word;

    assign accept = mem_req_valid && mem_req_ready;

    always_comb
    begin
        for (int i = 0; i < NUM_CHAN; i++)
        begin
            set_rd[i] = accept && !mem_req.wr && (mem_req.tag == CHAN_ID_W'(i));
            set_wr[i] = accept && mem_req.wr && (mem_req.tag == CHAN_ID_W'(i));
            clr_rd[i] = mem_rsp_valid && !mem_rsp.wr && (mem_rsp.tag == CHAN_ID_W'(i));
            clr_wr[i] = mem_rsp_valid && mem_rsp.wr && (mem_rsp.tag == CHAN_ID_W'(i));
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            read_pending <= '0;
            write_pending <= '0;
        end
        else
        begin
            read_pending <= (read_pending | set_rd) & ~clr_rd;
            write_pending <= (write_pending | set_wr) & ~clr_wr;
        end
    end

    // spread the valid lanes so any destination lane finds its item.
    always_comb
    begin
        case (mem_rsp.mask)
            4'b1111: rsp_word = mem_rsp.rdata;
            4'b1100: rsp_word = {2{mem_rsp.rdata[31:16]}};
            4'b0011: rsp_word = {2{mem_rsp.rdata[15:0]}};
            4'b1000: rsp_word = {4{mem_rsp.rdata[31:24]}};
            4'b0100: rsp_word = {4{mem_rsp.rdata[23:16]}};
            4'b0010: rsp_word = {4{mem_rsp.rdata[15:8]}};
            default: rsp_word = {4{mem_rsp.rdata[7:0]}};
        endcase
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NUM_CHAN; i++)
        begin
            if (clr_rd[i])
                rdata_chan[i] <= rsp_word;
        end
    end

endmodule

//--- dma_engine.sv
// dma engine top level joining register bank, scheduler, stepping and tracking.
`timescale 1ns/1ns

module dma_engine
    import dma_pkg::*;
#(
    parameter int NUM_CHAN = 4
)
(
    input  logic                clk,
    input  logic                rst,
    input  reg_req_t            reg_req,
    input  logic [NUM_REQ-1:0]  req,
    input  logic                mem_req_ready,
    input  mem_rsp_t            mem_rsp,
    input  logic                mem_rsp_valid,
    output logic [31:0]         reg_rdata,
    output mem_req_t            mem_req,
    output logic                mem_req_valid,
    output logic [NUM_CHAN-1:0] done
);

    chan_regs_t          regs [NUM_CHAN];
    chan_regs_t          regs_sel;
    logic [ADDR_W-1:0]   next_src;
    logic [ADDR_W-1:0]   next_dst;
    logic [ADDR_W-1:0]   next_cnt;
    logic [3:0]          src_mask;
    logic [3:0]          dst_mask;
    logic [NUM_CHAN-1:0] update;
    logic [NUM_CHAN-1:0] null_clear;
    logic [NUM_CHAN-1:0] read_pending;
    logic [NUM_CHAN-1:0] write_pending;
    logic [31:0]         rdata_chan [NUM_CHAN];

    dma_reg_file #(.NUM_CHAN(NUM_CHAN)) u_reg_file (
        .clk(clk), .rst(rst), .reg_req(reg_req), .update(update), .null_clear(null_clear),
        .next_src(next_src), .next_dst(next_dst), .next_cnt(next_cnt),
        .read_pending(read_pending), .write_pending(write_pending),
        .reg_rdata(reg_rdata), .regs(regs), .done(done)
    );

    dma_scheduler #(.NUM_CHAN(NUM_CHAN)) u_scheduler (
        .clk(clk), .rst(rst), .regs(regs), .req(req), .src_mask(src_mask),
        .dst_mask(dst_mask), .read_pending(read_pending), .write_pending(write_pending),
        .rdata_chan(rdata_chan), .mem_req_ready(mem_req_ready), .regs_sel(regs_sel),
        .mem_req(mem_req), .mem_req_valid(mem_req_valid), .update(update),
        .null_clear(null_clear)
    );

    dma_step_calc u_step_calc (
        .regs_sel(regs_sel), .next_src(next_src), .next_dst(next_dst),
        .next_cnt(next_cnt), .src_mask(src_mask), .dst_mask(dst_mask)
    );

    dma_resp_tracker #(.NUM_CHAN(NUM_CHAN)) u_resp_tracker (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready), .mem_rsp(mem_rsp), .mem_rsp_valid(mem_rsp_valid),
        .read_pending(read_pending), .write_pending(write_pending), .rdata_chan(rdata_chan)
    );

endmodule

//--- dma_properties.sv
// dma engine assertions on the memory request handshake, responses and done output.
`timescale 1ns/1ns

module dma_properties
    import dma_pkg::*;
#(
    parameter int NUM_CHAN = 4
)
(
    input logic                clk,
    input logic                rst,
    input mem_req_t            mem_req,
    input logic                mem_req_valid,
    input logic                mem_req_ready,
    input mem_rsp_t            mem_rsp,
    input logic                mem_rsp_valid,
    input logic [NUM_CHAN-1:0] read_pending,
    input logic [NUM_CHAN-1:0] write_pending,
    input logic [NUM_CHAN-1:0] done
);

    int fail_count = 0;

    req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else
    begin
        fail_count++;
        $error("memory request changed or dropped while waiting for ready");
    end

    reset_quiet: assert property (@(posedge clk)
        rst |-> !mem_req_valid && (done == '0))
    else
    begin
        fail_count++;
        $error("request valid or done set during reset");
    end

    rsp_owned: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |->
            (mem_rsp.wr ? write_pending[mem_rsp.tag] : read_pending[mem_rsp.tag]))
    else
    begin
        fail_count++;
        $error("response for a tag with no access outstanding");
    end

endmodule

bind dma_engine dma_properties #(.NUM_CHAN(NUM_CHAN)) u_props (.*);

//--- dma_checker.sv
// dma checker that compares memory writes and done timing with a reference model.
`timescale 1ns/1ns

module dma_checker
    import dma_pkg::*;
#(
    parameter int NUM_CHAN = 4
)
(
    input  logic                clk,
    input  logic                rst,
    input  reg_req_t            reg_req,
    input  mem_req_t            mem_req,
    input  logic                mem_req_valid,
    input  logic                mem_req_ready,
    input  mem_rsp_t            mem_rsp,
    input  logic                mem_rsp_valid,
    input  logic [NUM_CHAN-1:0] done,
    input  logic [7:0]          mem [4096],
    output int                  errors
);

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [3:0]        mask;
        logic [31:0]       data;  // item already placed in its lanes.
    } wr_item_t;

    typedef wr_item_t wr_list_t [$];

    logic [ADDR_W-1:0]   src_sh [NUM_CHAN];
    logic [ADDR_W-1:0]   dst_sh [NUM_CHAN];
    chan_ctrl_t          ctrl_sh [NUM_CHAN];
    wr_item_t            exp_q [NUM_CHAN][$];
    int                  wr_out [NUM_CHAN];
    logic [NUM_CHAN-1:0] armed;
    logic [NUM_CHAN-1:0] done_q;

    initial errors = 0;

    function automatic logic [31:0] lane_bits(input logic [3:0] mask);
        logic [31:0] bits;
        for (int b = 0; b < 4; b++)
            bits[8*b +: 8] = {8{mask[b]}};
        return bits;
    endfunction

    function automatic wr_list_t expected_writes(
        input logic [7:0]        m [4096],
        input logic [ADDR_W-1:0] src,
        input logic [ADDR_W-1:0] dst,
        input xfer_size_e        size,
        input logic              src_inc,
        input logic              dst_inc,
        input logic [ADDR_W-1:0] cnt,
        input logic              null_term
    );
        wr_list_t          q;
        wr_item_t          w;
        int                nb;
        int                n;
        logic [ADDR_W-1:0] s;
        logic [ADDR_W-1:0] d;
        logic [31:0]       item;
        nb = (size == SIZE_8) ? 1 : ((size == SIZE_16) ? 2 : 4);
        // items sit on a size boundary, an odd start rounds down.
        s = src & ~ADDR_W'(nb - 1);
        d = dst & ~ADDR_W'(nb - 1);
        n = int'(cnt) / nb;
        for (int k = 0; k < n; k++)
        begin
            item = '0;
            for (int b = 0; b < nb; b++)
                item[8*b +: 8] = m[int'(s[11:0]) + b];  // little endian.
            w.addr = {d[ADDR_W-1:2], 2'b00};
            w.mask = 4'((1 << nb) - 1) << d[1:0];
            w.data = item << (8 * d[1:0]);
            q.push_back(w);
            if (null_term && (item == '0))
                break;
            if (src_inc)
                s = s + ADDR_W'(nb);
            if (dst_inc)
                d = d + ADDR_W'(nb);
        end
        return q;
    endfunction

    always @(posedge clk)
    begin
        wr_item_t   e;
        wr_list_t   items;
        logic [1:0] ch;
        if (rst)
        begin
            armed = '0;
            done_q = '0;
            for (int c = 0; c < NUM_CHAN; c++)
                wr_out[c] = 0;
        end
        else
        begin
            if (reg_req.sel && reg_req.wr)
            begin
                ch = reg_req.off[5:4];
                case (reg_req.off[3:0])
                    OFF_SRC:  src_sh[ch] = reg_req.wdata[ADDR_W-1:0];
                    OFF_DST:  dst_sh[ch] = reg_req.wdata[ADDR_W-1:0];
                    OFF_CTRL: ctrl_sh[ch] = chan_ctrl_t'(reg_req.wdata[$bits(chan_ctrl_t)-1:0]);
                    OFF_CNT:
                    begin
                        items = expected_writes(mem, src_sh[ch], dst_sh[ch], ctrl_sh[ch].size,
                            ctrl_sh[ch].src_inc, ctrl_sh[ch].dst_inc,
                            reg_req.wdata[ADDR_W-1:0], ctrl_sh[ch].null_term);
                        foreach (items[k])
                            exp_q[ch].push_back(items[k]);
                        armed[ch] = (reg_req.wdata[ADDR_W-1:0] != '0);
                    end
                    default: ;
                endcase
            end

            if (mem_req_valid && mem_req_ready && mem_req.wr)
            begin
                ch = mem_req.tag;
                wr_out[ch]++;
                if (exp_q[ch].size() == 0)
                begin
                    errors++;
                    $display("ERROR @%0t: channel %0d wrote to %h when no write was expected",
                        $time, ch, mem_req.addr);
                end
                else
                begin
                    e = exp_q[ch].pop_front();
                    if ((mem_req.addr != e.addr) || (mem_req.mask != e.mask) ||
                        ((mem_req.wdata & lane_bits(mem_req.mask)) != e.data))
                    begin
                        errors++;
                        $display("ERROR @%0t: channel %0d write %h/%b/%h, expected %h/%b/%h",
                            $time, ch, mem_req.addr, mem_req.mask, mem_req.wdata,
                            e.addr, e.mask, e.data);
                    end
                end
            end
            if (mem_rsp_valid && mem_rsp.wr)
                wr_out[mem_rsp.tag]--;

            // done may only rise once every write has landed.
            for (int c = 0; c < NUM_CHAN; c++)
            begin
                if (done[c] && !done_q[c] && armed[c])
                begin
                    armed[c] = 1'b0;
                    if ((exp_q[c].size() != 0) || (wr_out[c] != 0))
                    begin
                        errors++;
                        $display("ERROR @%0t: channel %0d done with %0d writes missing, %0d open",
                            $time, c, exp_q[c].size(), wr_out[c]);
                    end
                end
            end
            done_q = done;
        end
    end

endmodule

//--- tb_dma.sv
// dma engine testbench with register programming, memory model and watchdog.
`timescale 1ns/1ns

module tb_dma;
    import dma_pkg::*;

    localparam int NUM_CHAN = 4;
    localparam int NUM_TESTS = 10;

    typedef struct packed {
        logic [1:0]        ch;
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        xfer_size_e        size;
        logic              src_inc;
        logic              dst_inc;
        logic              null_term;
        logic [ADDR_W-1:0] cnt;
    } test_t;

    typedef struct packed {
        logic [31:0] due;  // cycle from which the response may go out.
        mem_rsp_t    rsp;
    } pend_t;

    logic                clk = 1'b0;
    logic                rst;
    reg_req_t            reg_req;
    logic [NUM_REQ-1:0]  req;
    logic                mem_req_ready;
    mem_rsp_t            mem_rsp;
    logic                mem_rsp_valid;
    logic [31:0]         reg_rdata;
    mem_req_t            mem_req;
    logic                mem_req_valid;
    logic [NUM_CHAN-1:0] done;

    logic [7:0]  mem [4096];
    pend_t       rsp_q [NUM_CHAN][$];
    test_t       tests [NUM_TESTS];
    logic [31:0] cyc;
    logic        rand_req;
    int          seed = 49;
    int          total_bytes = 0;
    int          tb_errors;
    int          chk_errors;
    int          a_fails;

    dma_engine #(.NUM_CHAN(NUM_CHAN)) UUT (
        .clk(clk), .rst(rst), .reg_req(reg_req), .req(req), .mem_req_ready(mem_req_ready),
        .mem_rsp(mem_rsp), .mem_rsp_valid(mem_rsp_valid), .reg_rdata(reg_rdata),
        .mem_req(mem_req), .mem_req_valid(mem_req_valid), .done(done)
    );

    dma_checker #(.NUM_CHAN(NUM_CHAN)) u_checker (
        .clk(clk), .rst(rst), .reg_req(reg_req), .mem_req(mem_req),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_rsp(mem_rsp),
        .mem_rsp_valid(mem_rsp_valid), .done(done), .mem(mem), .errors(chk_errors)
    );

    always #10 clk = ~clk;

    // memory model accepts on the rising edge and queues a response per tag.
    always @(posedge clk)
    begin
        pend_t p;
        int    a;
        cyc = cyc + 1;
        if (!rst && mem_req_valid && mem_req_ready)
        begin
            a = int'(mem_req.addr[11:0]);
            p.rsp.wr = mem_req.wr;
            p.rsp.tag = mem_req.tag;
            p.rsp.mask = mem_req.mask;
            p.rsp.rdata = '0;
            if (mem_req.wr)
            begin
                for (int b = 0; b < 4; b++)
                    if (mem_req.mask[b])
                        mem[a + b] = mem_req.wdata[8*b +: 8];
            end
            else
                p.rsp.rdata = {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]};
            p.due = cyc + ($unsigned($random(seed)) % 6);  // 1 to 6 cycles.
            rsp_q[mem_req.tag].push_back(p);
        end
    end

    always @(negedge clk)
    begin
        int t;
        mem_req_ready = ($random(seed) & 3) != 0;
        req = rand_req ? NUM_REQ'($random(seed)) : '1;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        for (int k = 0; k < NUM_CHAN; k++)
        begin
            t = (k + int'(cyc)) % NUM_CHAN;  // rotate so tags interleave.
            if (!mem_rsp_valid && (rsp_q[t].size() > 0) && (rsp_q[t][0].due <= cyc))
            begin
                mem_rsp = rsp_q[t][0].rsp;
                mem_rsp_valid = 1'b1;
                void'(rsp_q[t].pop_front());
            end
        end
    end

    task automatic load_tests();
        // channel, source, destination, size, src inc, dst inc, null term, bytes.
        tests[0] = '{2'd0, 24'h000010, 24'h000810, SIZE_32, 1'b1, 1'b1, 1'b0, 24'd64};
        tests[1] = '{2'd1, 24'h000103, 24'h000905, SIZE_8, 1'b1, 1'b1, 1'b0, 24'd13};
        tests[2] = '{2'd2, 24'h000203, 24'h000A0E, SIZE_16, 1'b1, 1'b1, 1'b0, 24'd18};
        tests[3] = '{2'd3, 24'h000300, 24'h000B00, SIZE_32, 1'b1, 1'b0, 1'b0, 24'd32};
        tests[4] = '{2'd0, 24'h000341, 24'h000B41, SIZE_8, 1'b0, 1'b1, 1'b0, 24'd10};
        tests[5] = '{2'd1, 24'h000400, 24'h000C00, SIZE_8, 1'b1, 1'b1, 1'b1, 24'd40};
        tests[6] = '{2'd0, 24'h000500, 24'h000D00, SIZE_32, 1'b1, 1'b1, 1'b0, 24'd48};
        tests[7] = '{2'd1, 24'h000581, 24'h000D81, SIZE_8, 1'b1, 1'b1, 1'b0, 24'd21};
        tests[8] = '{2'd2, 24'h000602, 24'h000E02, SIZE_16, 1'b1, 1'b1, 1'b0, 24'd30};
        tests[9] = '{2'd3, 24'h000680, 24'h000E80, SIZE_32, 1'b1, 1'b1, 1'b0, 24'd40};
    endtask

    task automatic reg_write(input logic [1:0] ch, input logic [3:0] word,
                             input logic [31:0] data);
        @(negedge clk);
        reg_req.sel = 1'b1;
        reg_req.wr = 1'b1;
        reg_req.off = {ch, word};
        reg_req.wdata = data;
    endtask

    task automatic reg_read(input logic [1:0] ch, input logic [3:0] word,
                            output logic [31:0] data);
        @(negedge clk);
        reg_req = '0;
        reg_req.sel = 1'b1;
        reg_req.off = {ch, word};
        @(posedge clk);
        data = reg_rdata;
    endtask

    task automatic program_chan(input test_t t);
        chan_ctrl_t c;
        c.src_req = 4'(2 * t.ch);  // each channel owns two request lines.
        c.dst_req = 4'(2 * t.ch + 1);
        c.src_inc = t.src_inc;
        c.dst_inc = t.dst_inc;
        c.size = t.size;
        c.null_term = t.null_term;
        reg_write(t.ch, OFF_SRC, 32'(t.src));
        reg_write(t.ch, OFF_DST, 32'(t.dst));
        reg_write(t.ch, OFF_CTRL, 32'(c));
        reg_write(t.ch, OFF_CNT, 32'(t.cnt));
    endtask

    task automatic run_range(input int lo, input int hi, input logic random_req);
        logic [NUM_CHAN-1:0] mask;
        logic [31:0]         rd;
        mask = '0;
        rand_req = random_req;
        for (int i = lo; i <= hi; i++)
        begin
            program_chan(tests[i]);
            mask[tests[i].ch] = 1'b1;
        end
        @(negedge clk);
        reg_req = '0;
        repeat (2) @(posedge clk);  // done drops one cycle after the count write.
        while ((done & mask) != mask)
            @(posedge clk);
        rand_req = 1'b0;
        for (int i = lo; i <= hi; i++)
        begin
            reg_read(tests[i].ch, OFF_CNT, rd);
            if (rd != '0)
            begin
                tb_errors++;
                $display("ERROR @%0t: channel %0d count reads %h after done, expected 0",
                    $time, tests[i].ch, rd);
            end
        end
    endtask

    initial
    begin
        wait (total_bytes != 0);
        #(50 * total_bytes * 20 + 20000);
        $display("watchdog expired, the transfers did not finish");
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        rst = 1'b1;
        reg_req = '0;
        req = '1;
        mem_req_ready = 1'b0;
        mem_rsp = '0;
        mem_rsp_valid = 1'b0;
        rand_req = 1'b0;
        cyc = '0;
        tb_errors = 0;
        for (int i = 0; i < 4096; i++)
            mem[i] = 8'($random(seed));
        mem[12'h40A] = 8'h00;  // terminator for the null-terminate copy.
        load_tests();
        for (int i = 0; i < NUM_TESTS; i++)
            total_bytes += int'(tests[i].cnt);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(posedge clk);
        if (done != '1)
        begin
            tb_errors++;
            $display("ERROR @%0t: done is %b after reset, expected all ones", $time, done);
        end
        for (int i = 0; i < 6; i++)
            run_range(i, i, 1'b0);
        run_range(6, 9, 1'b1);  // all channels together.
        repeat (10) @(posedge clk);
        a_fails = UUT.u_props.fail_count;
        $display("errors: checker %0d, testbench %0d, assertions %0d",
            chk_errors, tb_errors, a_fails);
        if ((chk_errors + tb_errors + a_fails) == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- src.f
dma_pkg.sv
dma_reg_file.sv
dma_step_calc.sv
dma_scheduler.sv
dma_resp_tracker.sv
dma_engine.sv
dma_properties.sv
dma_checker.sv
tb_dma.sv
